// ==== pdp8_pkg.sv ====
package pdp8_pkg;

    localparam int WORD_W    = 12;                      // Machine word
    localparam int ADDR_W    = 15;                      // Field plus 12-bit address
    localparam int MEM_WORDS = 32768;                   // Eight fields of 4K

    localparam logic [0:WORD_W-1] NOP_WORD = 12'o7000;  // Instruction after reset

    // Every processor cycle runs x0, xW, x1, x2, x3
    typedef enum logic [4:0] {
        F0,
        FW,
        F1,
        F2,
        F3,
        D0,
        DW,
        D1,
        D2,
        D3,
        E0,
        EW,
        E1,
        E2,
        E3,
        H0,
        HW,
        H1,
        H2,
        H3,
        DB0,                                            // Data break, three clocks
        DB1,
        DB2
    } major_state_t;

    typedef enum logic [2:0] {
        AND,                                            // 0xxx
        TAD,
        ISZ,
        DCA,
        JMS,
        JMP,
        IOT,
        OPR                                             // 7xxx
    } opcode_t;

endpackage

// ==== core_mem.sv ====
`timescale 1ns/10ps

module core_mem (
    input  logic                        clk,
    input  logic [0:pdp8_pkg::ADDR_W-1] addr,
    input  logic [0:pdp8_pkg::WORD_W-1] din,
    input  logic                        write_en,
    output logic [0:pdp8_pkg::WORD_W-1] dout
);

    logic [0:pdp8_pkg::WORD_W-1] mem [0:pdp8_pkg::MEM_WORDS-1];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];                              // Old word on a write
    end

endmodule

// ==== mem_addr_unit.sv ====
`timescale 1ns/10ps

module mem_addr_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  pdp8_pkg::major_state_t      state,
    input  logic [0:pdp8_pkg::WORD_W-1] ac,
    input  logic [0:pdp8_pkg::WORD_W-1] sr,
    input  logic                        sw,
    input  logic                        skip,
    input  logic [0:2]                  IF,
    input  logic [0:2]                  DF,
    input  logic                        load_addr,
    input  logic                        deposit,
    input  logic                        load_ext,
    input  logic                        examine,
    input  logic [0:pdp8_pkg::WORD_W-1] mem_rdata,
    output logic [0:pdp8_pkg::ADDR_W-1] ma_addr,
    output logic [0:pdp8_pkg::WORD_W-1] ma_wdata,
    output logic                        ma_we,
    output logic [0:pdp8_pkg::WORD_W-1] instruction,
    output logic [0:pdp8_pkg::WORD_W-1] mdout,
    output logic [0:pdp8_pkg::ADDR_W-1] eaddr
);

    logic [0:pdp8_pkg::WORD_W-1] pc;
    logic [0:pdp8_pkg::WORD_W-1] next_pc;
    logic [0:pdp8_pkg::WORD_W-1] skip_pc;
    logic [0:pdp8_pkg::WORD_W-1] idx_tmp;               // Incremented auto-index pointer
    logic [0:pdp8_pkg::WORD_W-1] page_addr;
    logic                        index;
    logic                        panel_adv;             // Deposit or examine seen in H1
    pdp8_pkg::opcode_t           op;

    assign op        = pdp8_pkg::opcode_t'(instruction[0:2]);
    assign page_addr = {(instruction[4] ? pc[0:4] : 5'b00000), instruction[5:11]};
    assign ma_addr   = eaddr;

    always_ff @(posedge clk) begin
        if (reset) begin
            eaddr       <= '0;
            instruction <= pdp8_pkg::NOP_WORD;
            ma_we       <= 1'b0;
            index       <= 1'b0;
            panel_adv   <= 1'b0;
        end else begin
            ma_we <= 1'b0;                              // Write strobe lasts one clock
            case (state)
                pdp8_pkg::F0: pc <= eaddr[3:14];
                pdp8_pkg::FW: begin
                    instruction <= mem_rdata;
                    mdout       <= mem_rdata;
                end
                pdp8_pkg::F2: begin
                    next_pc <= pc + 12'o0001;
                    skip_pc <= pc + 12'o0002;
                end
                pdp8_pkg::F3: begin
                    case (op)
                        pdp8_pkg::IOT, pdp8_pkg::OPR: begin
                            if (skip) begin
                                eaddr <= {IF, skip_pc};
                            end else begin
                                eaddr <= {IF, next_pc};
                            end
                        end
                        default: eaddr <= {IF, page_addr};  // Operand or JMP target
                    endcase
                end
                pdp8_pkg::D0: index <= (eaddr[3:11] == 9'o001);  // Pointer in 0010 to 0017
                pdp8_pkg::DW: mdout <= mem_rdata;
                pdp8_pkg::D1: begin
                    if (index) begin
                        ma_wdata <= mdout + 12'o0001;
                        idx_tmp  <= mdout + 12'o0001;
                        ma_we    <= 1'b1;               // Pointer written back in D2
                    end
                end
                pdp8_pkg::D3: begin
                    if (index) begin
                        eaddr[3:14] <= idx_tmp;
                        index       <= 1'b0;
                    end else begin
                        eaddr[3:14] <= mdout;
                    end
                    case (op)
                        pdp8_pkg::JMP, pdp8_pkg::JMS: eaddr[0:2] <= IF;
                        default: eaddr[0:2] <= DF;      // Data references use DF
                    endcase
                end
                pdp8_pkg::EW: mdout <= mem_rdata;
                pdp8_pkg::E1: begin
                    case (op)
                        pdp8_pkg::ISZ: begin
                            ma_wdata <= mdout + 12'o0001;
                            ma_we    <= 1'b1;
                            if (mdout == 12'o7777) begin
                                next_pc <= skip_pc;
                            end
                        end
                        pdp8_pkg::DCA: begin
                            ma_wdata <= ac;
                            ma_we    <= 1'b1;
                        end
                        pdp8_pkg::JMS: begin
                            ma_wdata <= next_pc;        // Return address
                            ma_we    <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                pdp8_pkg::E2: begin
                    if (op == pdp8_pkg::JMS) begin
                        next_pc <= eaddr[3:14] + 12'o0001;  // Continue past the link word
                    end
                end
                pdp8_pkg::E3: eaddr <= {IF, next_pc};
                pdp8_pkg::HW: mdout <= mem_rdata;
                pdp8_pkg::H1: begin
                    panel_adv <= deposit | examine;
                    if (load_addr) begin
                        eaddr[3:14] <= sw ? 12'o7777 : sr;
                    end else if (deposit) begin
                        ma_wdata <= sr;
                        ma_we    <= 1'b1;
                    end else if (load_ext) begin
                        eaddr[0:2] <= sr[6:8];
                    end
                end
                pdp8_pkg::H2: begin
                    if (panel_adv) begin
                        eaddr[3:14] <= eaddr[3:14] + 12'o0001;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== major_state_seq.sv ====
`timescale 1ns/10ps

module major_state_seq (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,
    input  logic [0:pdp8_pkg::WORD_W-1] instruction,
    input  logic                        data_break,
    output pdp8_pkg::major_state_t      state
);

    pdp8_pkg::major_state_t next_state;
    pdp8_pkg::major_state_t instr_end;                  // Where a finished instruction goes
    pdp8_pkg::opcode_t      op;
    logic                   indirect;

    assign op       = pdp8_pkg::opcode_t'(instruction[0:2]);
    assign indirect = instruction[3];

    always_comb begin
        instr_end = pdp8_pkg::H0;
        if (run) begin
            instr_end = pdp8_pkg::F0;
        end
        case (state)
            pdp8_pkg::F0: begin
                if (data_break) begin
                    next_state = pdp8_pkg::DB0;
                end else begin
                    next_state = pdp8_pkg::FW;
                end
            end
            pdp8_pkg::FW: next_state = pdp8_pkg::F1;
            pdp8_pkg::F1: next_state = pdp8_pkg::F2;
            pdp8_pkg::F2: next_state = pdp8_pkg::F3;
            pdp8_pkg::F3: begin
                if (op == pdp8_pkg::IOT || op == pdp8_pkg::OPR) begin
                    next_state = instr_end;
                end else if (indirect) begin
                    next_state = pdp8_pkg::D0;
                end else if (op == pdp8_pkg::JMP) begin
                    next_state = instr_end;
                end else begin
                    next_state = pdp8_pkg::E0;
                end
            end
            pdp8_pkg::D0: next_state = pdp8_pkg::DW;
            pdp8_pkg::DW: next_state = pdp8_pkg::D1;
            pdp8_pkg::D1: next_state = pdp8_pkg::D2;
            pdp8_pkg::D2: next_state = pdp8_pkg::D3;
            pdp8_pkg::D3: begin
                if (op == pdp8_pkg::JMP) begin
                    next_state = instr_end;
                end else begin
                    next_state = pdp8_pkg::E0;
                end
            end
            pdp8_pkg::E0: next_state = pdp8_pkg::EW;
            pdp8_pkg::EW: next_state = pdp8_pkg::E1;
            pdp8_pkg::E1: next_state = pdp8_pkg::E2;
            pdp8_pkg::E2: next_state = pdp8_pkg::E3;
            pdp8_pkg::E3: next_state = instr_end;
            pdp8_pkg::H0: next_state = pdp8_pkg::HW;
            pdp8_pkg::HW: next_state = pdp8_pkg::H1;
            pdp8_pkg::H1: next_state = pdp8_pkg::H2;
            pdp8_pkg::H2: next_state = pdp8_pkg::H3;
            pdp8_pkg::H3: next_state = instr_end;   // Panel loop until run
            pdp8_pkg::DB0: next_state = pdp8_pkg::DB1;
            pdp8_pkg::DB1: next_state = pdp8_pkg::DB2;
            pdp8_pkg::DB2: next_state = pdp8_pkg::F0;  // Fetch starts over
            default: next_state = pdp8_pkg::H0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pdp8_pkg::H0;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== dma_channel.sv ====
`timescale 1ns/10ps

module dma_channel (
    input  logic                        clk,
    input  logic                        reset,
    input  pdp8_pkg::major_state_t      state,
    input  logic                        data_break,
    input  logic                        dma_start,
    input  logic                        dma_dir,
    input  logic [0:pdp8_pkg::ADDR_W-1] dma_start_addr,
    input  logic [0:pdp8_pkg::WORD_W-1] disk_word,
    input  logic [0:pdp8_pkg::WORD_W-1] mem_rdata,
    output logic                        dma_req,
    output logic [0:pdp8_pkg::ADDR_W-1] dma_addr,
    output logic [0:pdp8_pkg::WORD_W-1] dma_wdata,
    output logic                        dma_we,
    output logic [0:pdp8_pkg::WORD_W-1] mem2disk,
    output logic                        dma_done
);

    logic to_disk;                                      // High for memory to disk
    logic accept;

    assign accept = dma_start & ~dma_req;               // Starts while busy are dropped
    assign dma_we = data_break & (state == pdp8_pkg::DB1) & ~to_disk;

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_req  <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            dma_done <= 1'b0;
            if (accept) begin
                dma_req <= 1'b1;
            end
            if (data_break && state == pdp8_pkg::DB1) begin
                dma_done <= 1'b1;                       // High through DB2
            end
            if (state == pdp8_pkg::DB2) begin
                dma_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dma_addr  <= dma_start_addr;
            to_disk   <= dma_dir;
            dma_wdata <= disk_word;
        end
        // Read was addressed from F0, so the word is ready as DB2 begins
        if (data_break && state == pdp8_pkg::DB1 && to_disk) begin
            mem2disk <= mem_rdata;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    input  pdp8_pkg::major_state_t      state,
    input  logic                        dma_req,
    input  logic [0:pdp8_pkg::ADDR_W-1] ma_addr,
    input  logic [0:pdp8_pkg::WORD_W-1] ma_wdata,
    input  logic                        ma_we,
    input  logic [0:pdp8_pkg::ADDR_W-1] dma_addr,
    input  logic [0:pdp8_pkg::WORD_W-1] dma_wdata,
    input  logic                        dma_we,
    output logic [0:pdp8_pkg::ADDR_W-1] mem_addr,
    output logic [0:pdp8_pkg::WORD_W-1] mem_wdata,
    output logic                        mem_we,
    output logic                        data_break
);

    logic grant;
    logic grab;

    assign grab       = (state == pdp8_pkg::F0) & dma_req;  // Only between instructions
    assign data_break = grant | grab;

    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
        end else if (grab) begin
            grant <= 1'b1;
        end else if (state == pdp8_pkg::DB2) begin
            grant <= 1'b0;                              // Processor gets it back in F0
        end
    end

    always_comb begin
        if (data_break) begin
            mem_addr  = dma_addr;
            mem_wdata = dma_wdata;
            mem_we    = dma_we;
        end else begin
            mem_addr  = ma_addr;
            mem_wdata = ma_wdata;
            mem_we    = ma_we;
        end
    end

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [0:pdp8_pkg::WORD_W-1] ac,
    input  logic [0:pdp8_pkg::WORD_W-1] sr,
    input  logic                        sw,
    input  logic                        skip,
    input  logic [0:2]                  IF,
    input  logic [0:2]                  DF,
    input  logic                        run,
    input  logic                        load_addr,
    input  logic                        deposit,
    input  logic                        examine,
    input  logic                        load_ext,
    input  logic                        dma_start,
    input  logic                        dma_dir,
    input  logic [0:pdp8_pkg::ADDR_W-1] dma_start_addr,
    input  logic [0:pdp8_pkg::WORD_W-1] disk_word,
    output logic [0:pdp8_pkg::ADDR_W-1] eaddr,
    output logic [0:pdp8_pkg::WORD_W-1] instruction,
    output logic [0:pdp8_pkg::WORD_W-1] mdout,
    output logic [0:pdp8_pkg::WORD_W-1] mem2disk,
    output logic                        dma_done
);

    pdp8_pkg::major_state_t      state;
    logic                        data_break;
    logic                        dma_req;
    logic [0:pdp8_pkg::ADDR_W-1] ma_addr;
    logic [0:pdp8_pkg::WORD_W-1] ma_wdata;
    logic                        ma_we;
    logic [0:pdp8_pkg::ADDR_W-1] dma_addr;
    logic [0:pdp8_pkg::WORD_W-1] dma_wdata;
    logic                        dma_we;
    logic [0:pdp8_pkg::ADDR_W-1] mem_addr;
    logic [0:pdp8_pkg::WORD_W-1] mem_wdata;
    logic                        mem_we;
    logic [0:pdp8_pkg::WORD_W-1] mem_rdata;

    core_mem u_core_mem (
        .clk      (clk),
        .addr     (mem_addr),
        .din      (mem_wdata),
        .write_en (mem_we),
        .dout     (mem_rdata)
    );

    mem_addr_unit u_mau (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .ac          (ac),
        .sr          (sr),
        .sw          (sw),
        .skip        (skip),
        .IF          (IF),
        .DF          (DF),
        .load_addr   (load_addr),
        .deposit     (deposit),
        .load_ext    (load_ext),
        .examine     (examine),
        .mem_rdata   (mem_rdata),
        .ma_addr     (ma_addr),
        .ma_wdata    (ma_wdata),
        .ma_we       (ma_we),
        .instruction (instruction),
        .mdout       (mdout),
        .eaddr       (eaddr)
    );

    major_state_seq u_seq (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .instruction (instruction),
        .data_break  (data_break),
        .state       (state)
    );

    dma_channel u_dma (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .data_break     (data_break),
        .dma_start      (dma_start),
        .dma_dir        (dma_dir),
        .dma_start_addr (dma_start_addr),
        .disk_word      (disk_word),
        .mem_rdata      (mem_rdata),
        .dma_req        (dma_req),
        .dma_addr       (dma_addr),
        .dma_wdata      (dma_wdata),
        .dma_we         (dma_we),
        .mem2disk       (mem2disk),
        .dma_done       (dma_done)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .dma_req    (dma_req),
        .ma_addr    (ma_addr),
        .ma_wdata   (ma_wdata),
        .ma_we      (ma_we),
        .dma_addr   (dma_addr),
        .dma_wdata  (dma_wdata),
        .dma_we     (dma_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .data_break (data_break)
    );

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys;

    logic        clk = 1'b0;
    logic        reset;
    logic [0:11] ac;
    logic [0:11] sr;
    logic        sw;
    logic        skip;
    logic [0:2]  IF;
    logic [0:2]  DF;
    logic        run;
    logic        load_addr;
    logic        deposit;
    logic        examine;
    logic        load_ext;
    logic        dma_start;
    logic        dma_dir;
    logic [0:14] dma_start_addr;
    logic [0:11] disk_word;
    logic [0:14] eaddr;
    logic [0:11] instruction;
    logic [0:11] mdout;
    logic [0:11] mem2disk;
    logic        dma_done;

    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 4000;                    // About twice the length of all tests
    int          seed = 44770;
    logic [0:14] panel_addr = 15'o00000;                // Address the panel should point at
    logic [0:14] fetch_addr [0:3];                      // eaddr seen in each F0 of a run
    int          fetch_cycle [0:3];

    mem_subsys_top dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR time=%0t %s got %0o expected %0o", $time, name, got, exp);
        end
    endtask

    function automatic logic [0:11] rand_word();
        int r;
        r = $random(seed);
        return r[11:0];
    endfunction

    // Returns at the falling edge inside state s
    task automatic wait_state(input pdp8_pkg::major_state_t s);
        @(negedge clk);
        while (dut0.state != s) begin
            @(negedge clk);
        end
    endtask

    // One-clock strobe that is high during H1; which = load_addr, deposit, examine, load_ext
    task automatic panel_strobe(input logic [0:3] which, input logic [0:11] value);
        wait_state(pdp8_pkg::HW);
        @(posedge clk);
        sr        <= value;
        load_addr <= which[0];
        deposit   <= which[1];
        examine   <= which[2];
        load_ext  <= which[3];
        @(posedge clk);
        load_addr <= 1'b0;
        deposit   <= 1'b0;
        examine   <= 1'b0;
        load_ext  <= 1'b0;
    endtask

    task automatic set_addr(input logic [0:11] addr);
        panel_strobe(4'b1000, addr);
        panel_addr[3:14] = sw ? 12'o7777 : addr;
    endtask

    task automatic load_field(input logic [0:2] field);
        panel_strobe(4'b0001, {6'b000000, field, 3'b000});
        panel_addr[0:2] = field;
    endtask

    task automatic deposit_word(input logic [0:11] word);
        panel_strobe(4'b0100, word);
        wait_state(pdp8_pkg::H3);
        panel_addr[3:14] = panel_addr[3:14] + 12'o0001;
        check("eaddr", 32'(eaddr), 32'(panel_addr));
    endtask

    // mdout was loaded in HW, so it is stable through the rest of the halt cycle
    task automatic examine_word(input logic [0:11] exp);
        panel_strobe(4'b0010, 12'o0000);
        @(negedge clk);
        check($sformatf("mdout at %0o", panel_addr), 32'(mdout), 32'(exp));
        wait_state(pdp8_pkg::H3);
        panel_addr[3:14] = panel_addr[3:14] + 12'o0001;
        check("eaddr", 32'(eaddr), 32'(panel_addr));
    endtask

    task automatic start_run(input logic [0:11] start);
        set_addr(start);
        wait_state(pdp8_pkg::H0);
        @(posedge clk);
        run <= 1'b1;
    endtask

    // Runs count instructions, then waits for the halt loop
    task automatic run_program(input logic [0:11] start, input int count);
        int i;
        start_run(start);
        for (i = 0; i < count; i++) begin
            wait_state(pdp8_pkg::F0);
            fetch_addr[i]  = eaddr;
            fetch_cycle[i] = cycles;
            if (i == count - 1) begin
                @(posedge clk);
                run <= 1'b0;                            // Last instruction ends in H0
            end
        end
        wait_state(pdp8_pkg::H0);
    endtask

    task automatic start_transfer(input logic dir, input logic [0:14] addr,
                                  input logic [0:11] word);
        @(posedge clk);
        dma_dir        <= dir;
        dma_start_addr <= addr;
        disk_word      <= word;
        dma_start      <= 1'b1;
        @(posedge clk);
        dma_start <= 1'b0;
    endtask

    task automatic wait_dma_done;
        @(negedge clk);
        while (!dma_done) begin
            @(negedge clk);
        end
    endtask

    task automatic panel_deposit_examine;
        logic [0:11] words [0:2];
        int          i;
        @(posedge clk);
        sw <= 1'b1;
        set_addr(12'o0000);
        @(negedge clk);
        check("eaddr", 32'(eaddr), 32'o07777);          // Switch forces all ones
        @(posedge clk);
        sw <= 1'b0;
        set_addr(12'o0200);
        for (i = 0; i < 3; i++) begin
            words[i] = rand_word();
            deposit_word(words[i]);
        end
        set_addr(12'o0200);
        for (i = 0; i < 3; i++) begin
            examine_word(words[i]);
        end
    endtask

    task automatic store_and_skip;
        logic [0:11] acc;
        acc = rand_word() | 12'o4000;                   // Never 0000 or 0005
        @(posedge clk);
        ac <= acc;
        set_addr(12'o0200);
        deposit_word(12'o3050);                         // DCA 0050
        deposit_word(12'o2051);                         // ISZ 0051
        deposit_word(12'o3052);                         // Would clobber 0052 if not skipped
        deposit_word(12'o7000);
        set_addr(12'o0050);
        deposit_word(12'o0000);
        deposit_word(12'o7777);
        deposit_word(12'o0005);
        run_program(12'o0200, 3);
        check("eaddr", 32'(fetch_addr[1]), 32'o0201);
        check("eaddr", 32'(fetch_addr[2]), 32'o0203);
        check("DCA clocks", fetch_cycle[1] - fetch_cycle[0], 10);
        set_addr(12'o0050);
        examine_word(acc);
        examine_word(12'o0000);
        examine_word(12'o0005);
    endtask

    task automatic auto_index_store;
        logic [0:11] acc;
        acc = rand_word() | 12'o4000;
        @(posedge clk);
        ac <= acc;
        set_addr(12'o0010);
        deposit_word(12'o0300);
        set_addr(12'o0301);
        deposit_word(~acc);
        set_addr(12'o0200);
        deposit_word(12'o3410);                         // DCA I 0010
        deposit_word(12'o7000);
        run_program(12'o0200, 2);
        check("eaddr", 32'(fetch_addr[1]), 32'o0201);
        check("DCA I clocks", fetch_cycle[1] - fetch_cycle[0], 15);
        set_addr(12'o0010);
        examine_word(12'o0301);
        set_addr(12'o0301);
        examine_word(acc);
    endtask

    // 0400 is off the page of 0200, so JMS goes through a pointer
    task automatic jms_and_jmp;
        set_addr(12'o0020);
        deposit_word(12'o0400);
        set_addr(12'o0200);
        deposit_word(12'o4420);                         // JMS I 0020
        deposit_word(12'o5250);                         // JMP 0250
        set_addr(12'o0250);
        deposit_word(12'o7000);
        set_addr(12'o0400);
        deposit_word(12'o0000);
        deposit_word(12'o7000);
        run_program(12'o0200, 2);
        check("eaddr", 32'(fetch_addr[1]), 32'o0401);
        check("JMS I clocks", fetch_cycle[1] - fetch_cycle[0], 15);
        set_addr(12'o0400);
        examine_word(12'o0201);
        run_program(12'o0201, 2);
        check("eaddr", 32'(fetch_addr[1]), 32'o0250);
        check("JMP clocks", fetch_cycle[1] - fetch_cycle[0], 5);
    endtask

    task automatic data_break_transfers;
        logic [0:11] word;
        word = rand_word();
        set_addr(12'o0200);
        deposit_word(12'o5200);                         // JMP 0200, tight loop
        set_addr(12'o1000);
        deposit_word(~word);
        start_run(12'o0200);
        wait_state(pdp8_pkg::F0);
        start_transfer(1'b0, 15'o01000, word);
        wait_dma_done();
        @(negedge clk);
        check("dma_done", 32'(dma_done), 32'd0);
        start_transfer(1'b1, 15'o01000, ~word);
        wait_dma_done();
        check("mem2disk", 32'(mem2disk), 32'(word));
        wait_state(pdp8_pkg::F0);
        check("eaddr", 32'(eaddr), 32'o0200);           // Loop resumes after the break
        @(posedge clk);
        run <= 1'b0;
        wait_state(pdp8_pkg::H0);
        set_addr(12'o1000);
        examine_word(word);
    endtask

    task automatic field_select;
        logic [0:11] word;
        word = rand_word();
        set_addr(12'o0600);
        deposit_word(~word);                            // Same offset in field 0
        load_field(3'd2);
        @(negedge clk);
        check("eaddr[0:2]", 32'(eaddr[0:2]), 32'd2);
        set_addr(12'o0600);
        deposit_word(word);
        set_addr(12'o0600);
        examine_word(word);
        load_field(3'd0);
        set_addr(12'o0600);
        examine_word(~word);
    endtask

    initial begin
        reset          <= 1'b1;
        ac             <= 12'o0000;
        sr             <= 12'o0000;
        sw             <= 1'b0;
        skip           <= 1'b0;
        IF             <= 3'd0;
        DF             <= 3'd0;
        run            <= 1'b0;
        load_addr      <= 1'b0;
        deposit        <= 1'b0;
        examine        <= 1'b0;
        load_ext       <= 1'b0;
        dma_start      <= 1'b0;
        dma_dir        <= 1'b0;
        dma_start_addr <= 15'o00000;
        disk_word      <= 12'o0000;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check("state", 32'(dut0.state), 32'(pdp8_pkg::H0));
        check("eaddr", 32'(eaddr), 32'd0);
        check("instruction", 32'(instruction), 32'o7000);
        check("dma_done", 32'(dma_done), 32'd0);
        @(posedge clk);
        reset <= 1'b0;
        panel_deposit_examine();
        store_and_skip();
        auto_index_store();
        jms_and_jmp();
        data_break_transfers();
        field_select();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
pdp8_pkg.sv
core_mem.sv
mem_addr_unit.sv
major_state_seq.sv
dma_channel.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" &&
    verilator --binary --timing -f list.f --top-module tb_mem_subsys -o tb_sim &&
    ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TEST PASS$" &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }
